// File: verilog/gpc_dmem_pkg.sv
// Data memory shared definitions

`default_nettype none

package gpc_dmem_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------

    // Data word
    localparam int WORD_WIDTH = 32;
    // Byte address, 4 KB of storage
    localparam int ADRS_WIDTH = 12;
    // Byte lanes per word
    localparam int NUM_BYTES  = WORD_WIDTH / 8;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADRS_WIDTH-1:0] byte_addr_t;
    // Byte address without the two lane bits
    typedef logic [ADRS_WIDTH-3:0] word_addr_t;
    // One enable per byte lane
    typedef logic [NUM_BYTES-1:0]  byteena_t;
    typedef logic [1:0]            size_t;

    // Access size codes
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // ------------------------------------------------------------
    // Port bundles
    // ------------------------------------------------------------

    // Core load/store request
    typedef struct packed {
        logic       rd;          // load strobe
        logic       wr;          // store strobe
        byte_addr_t addr;
        size_t      size;
        logic       is_unsigned; // zero-extend on load
        word_t      data;        // store data, low-aligned
    } lsu_req_t;

    // One RAM port, word addressed
    typedef struct packed {
        word_addr_t addr;
        logic       wren;
        byteena_t   byteena;
        word_t      data;
    } mem_port_t;

endpackage

`default_nettype wire

// File: verilog/mem.sv
// Dual-port byte-enable RAM

`timescale 1ns/1ps
`default_nettype none

module mem #(
    parameter int ADRS_WIDTH = gpc_dmem_pkg::ADRS_WIDTH
) (
    input  logic                    clock,
    // Load/store side
    input  gpc_dmem_pkg::mem_port_t port_a,
    output gpc_dmem_pkg::word_t     q_a,
    // External side
    input  gpc_dmem_pkg::mem_port_t port_b,
    output gpc_dmem_pkg::word_t     q_b
);

    import gpc_dmem_pkg::*;

    // Number of bytes in the array
    localparam int DEPTH = 2 ** ADRS_WIDTH;

    // Byte storage and its next state
    logic [7:0] mem_array [DEPTH];
    logic [7:0] next_mem  [DEPTH];

    // Read words before the output register
    word_t      pre_q_a;
    word_t      pre_q_b;

    // Word address plus lane bits must span the array
    if (ADRS_WIDTH != $bits(word_addr_t) + 2) begin : g_width_check
        $error("mem: ADRS_WIDTH does not match word_addr_t");
    end

    // ------------------------------------------------------------
    // Write merge
    // ------------------------------------------------------------

    always_comb begin
        next_mem = mem_array;
        // Port a lanes go in first
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (port_a.wren && port_a.byteena[i]) begin
                next_mem[{port_a.addr, 2'(i)}] = port_a.data[8*i +: 8];
            end
        end
        // Port b lanes overwrite, so b wins a shared word
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (port_b.wren && port_b.byteena[i]) begin
                next_mem[{port_b.addr, 2'(i)}] = port_b.data[8*i +: 8];
            end
        end
    end

    // Array update at the edge
    always_ff @(posedge clock) begin
        mem_array <= next_mem;
    end

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------

    // Little-endian word from four bytes of the old contents
    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            pre_q_a[8*i +: 8] = mem_array[{port_a.addr, 2'(i)}];
            pre_q_b[8*i +: 8] = mem_array[{port_b.addr, 2'(i)}];
        end
    end

    // Synchronous read, one cycle
    // Same-edge write is not visible here
    always_ff @(posedge clock) begin
        q_a <= pre_q_a;
        q_b <= pre_q_b;
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    // Both drivers settle once the first edge has passed
    wren_known: assert property (@(posedge clock)
        1'b1 ##1 1'b1 |-> !$isunknown({port_a.wren, port_b.wren}))
        else $error("mem: write enable unknown at %0t", $time);

endmodule

`default_nettype wire

// File: verilog/lsu_port.sv
// Load/store alignment port

`timescale 1ns/1ps
`default_nettype none

module lsu_port (
    input  logic                    clock,
    input  logic                    rst,
    // Core request
    input  gpc_dmem_pkg::lsu_req_t  lsu_req,
    // RAM port a
    output gpc_dmem_pkg::mem_port_t port_a,
    input  gpc_dmem_pkg::word_t     q_a,
    // Core results
    output gpc_dmem_pkg::word_t     load_data,
    output logic                    load_valid,
    output logic                    misaligned
);

    import gpc_dmem_pkg::*;

    // Request decode
    logic [1:0] offset;
    logic       access;
    logic       is_misaligned;

    // Store lanes
    byteena_t   store_be;
    word_t      store_data;

    // Load stage, one cycle behind the strobe
    logic [1:0] ld_offset;
    size_t      ld_size;
    logic       ld_unsigned;

    // Load extraction
    word_t      ld_shifted;
    logic       byte_fill;
    logic       half_fill;

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------

    // Lane of the first byte
    assign offset = lsu_req.addr[1:0];
    assign access = lsu_req.rd | lsu_req.wr;

    // Alignment by size
    always_comb begin
        case (lsu_req.size)
            SIZE_BYTE: is_misaligned = 1'b0;
            SIZE_HALF: is_misaligned = offset[0];
            SIZE_WORD: is_misaligned = (offset != 2'b00);
            // Unused size code is rejected too
            default:   is_misaligned = 1'b1;
        endcase
    end

    // ------------------------------------------------------------
    // Store path
    // ------------------------------------------------------------

    // Byte enables follow size and lane
    always_comb begin
        case (lsu_req.size)
            SIZE_BYTE: store_be = byteena_t'(4'b0001 << offset);
            SIZE_HALF: store_be = byteena_t'(4'b0011 << offset);
            default:   store_be = '1;
        endcase
    end

    // Low-aligned data moved up to its lanes
    assign store_data = lsu_req.data << {offset, 3'b000};

    // Address always driven so loads read every cycle
    always_comb begin
        port_a.addr    = lsu_req.addr[ADRS_WIDTH-1:2];
        // Only aligned stores reach the array
        port_a.wren    = lsu_req.wr & ~is_misaligned;
        port_a.byteena = store_be;
        port_a.data    = store_data;
    end

    // ------------------------------------------------------------
    // Load path
    // ------------------------------------------------------------

    // Control strobes
    always_ff @(posedge clock) begin
        if (rst) begin
            load_valid <= 1'b0;
            misaligned <= 1'b0;
        end else begin
            load_valid <= lsu_req.rd & ~is_misaligned;
            misaligned <= access & is_misaligned;
        end
    end

    // Selection info travels with the RAM read
    always_ff @(posedge clock) begin
        ld_offset   <= offset;
        ld_size     <= lsu_req.size;
        ld_unsigned <= lsu_req.is_unsigned;
    end

    // Addressed lane moved down to bit 0
    assign ld_shifted = q_a >> {ld_offset, 3'b000};

    // Sign bits, zero when unsigned
    assign byte_fill = ~ld_unsigned & ld_shifted[7];
    assign half_fill = ~ld_unsigned & ld_shifted[15];

    always_comb begin
        case (ld_size)
            SIZE_BYTE: load_data = {{(WORD_WIDTH-8){byte_fill}}, ld_shifted[7:0]};
            SIZE_HALF: load_data = {{(WORD_WIDTH-16){half_fill}}, ld_shifted[15:0]};
            // Full word, no shift needed
            default:   load_data = q_a;
        endcase
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    // Core never loads and stores at once
    rd_wr_exclusive: assert property (@(posedge clock) disable iff (rst)
        !(lsu_req.rd && lsu_req.wr))
        else $error("lsu_port: rd and wr both high at %0t", $time);

endmodule

`default_nettype wire

// File: verilog/gpc_dmem_top.sv
// Data memory subsystem top

`timescale 1ns/1ps
`default_nettype none

module gpc_dmem_top (
    input  logic                    clock,
    input  logic                    rst,
    // ------------------------------------------------------------
    // Core load/store side
    // ------------------------------------------------------------
    input  gpc_dmem_pkg::lsu_req_t  lsu_req,
    output gpc_dmem_pkg::word_t     load_data,
    output logic                    load_valid,
    output logic                    misaligned,
    // ------------------------------------------------------------
    // External loader/debug side
    // ------------------------------------------------------------
    input  gpc_dmem_pkg::mem_port_t ext_port,
    output gpc_dmem_pkg::word_t     ext_q
);

    import gpc_dmem_pkg::*;

    // Load/store port to RAM port a
    mem_port_t port_a;
    // Raw read word back to the load path
    word_t     q_a;

    // Alignment, enables and load extraction
    lsu_port lsu_port_inst (
        .clock      (clock),
        .rst        (rst),
        .lsu_req    (lsu_req),
        .port_a     (port_a),
        .q_a        (q_a),
        .load_data  (load_data),
        .load_valid (load_valid),
        .misaligned (misaligned)
    );

    // Shared RAM
    // External port goes straight to port b
    mem #(
        .ADRS_WIDTH (ADRS_WIDTH)
    ) mem_inst (
        .clock  (clock),
        .port_a (port_a),
        .q_a    (q_a),
        .port_b (ext_port),
        .q_b    (ext_q)
    );

endmodule

`default_nettype wire

// File: dv/gpc_dmem_checker.sv
// Data memory checker and reference model

`timescale 1ns/1ps
`default_nettype none

module gpc_dmem_checker (
    input  logic                    clock,
    input  logic                    rst,
    input  gpc_dmem_pkg::lsu_req_t  lsu_req,
    input  gpc_dmem_pkg::word_t     load_data,
    input  logic                    load_valid,
    input  logic                    misaligned,
    input  gpc_dmem_pkg::mem_port_t ext_port,
    input  gpc_dmem_pkg::word_t     ext_q,
    output int                      error_count,
    output int                      access_count,
    output int                      load_count
);

    import gpc_dmem_pkg::*;

    localparam int DEPTH = 2 ** ADRS_WIDTH;

    // Byte model, plus which bytes have ever been written
    logic [7:0] model_mem   [DEPTH];
    bit         model_known [DEPTH];

    // Expected results for the cycle after an edge
    bit         exp_valid;
    bit         exp_misaligned;
    word_t      exp_load;
    word_t      exp_load_mask;
    word_t      exp_ext;
    word_t      exp_ext_mask;
    bit         started = 1'b0;

    int         errors = 0;
    int         accesses = 0;
    int         loads = 0;

    assign error_count  = errors;
    assign access_count = accesses;
    assign load_count   = loads;

    // ------------------------------------------------------------
    // Model rules
    // ------------------------------------------------------------

    // Aligned only when the address is a multiple of the access size
    function automatic bit is_misaligned(size_t size, logic [1:0] offset);
        return (int'(offset) % size_bytes(size)) != 0;
    endfunction

    function automatic int size_bytes(size_t size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // Loaded bytes from the model, then extension
    task automatic predict_load(byte_addr_t addr, size_t size, logic is_unsigned);
        byte_addr_t a;
        int         n;
        logic       sign;
        n = size_bytes(size);
        exp_load      = '0;
        exp_load_mask = '0;
        for (int i = 0; i < n; i++) begin
            a = addr + byte_addr_t'(i);
            exp_load[8*i +: 8] = model_mem[a];
            if (model_known[a]) begin
                exp_load_mask[8*i +: 8] = 8'hff;
            end
        end
        // Top loaded bit, or zero when unsigned
        sign = ~is_unsigned & exp_load[8*n-1];
        for (int b = 8 * n; b < WORD_WIDTH; b++) begin
            exp_load[b]      = sign;
            exp_load_mask[b] = exp_load_mask[8*n-1];
        end
    endtask

    // Raw word seen by the external port
    task automatic predict_ext();
        byte_addr_t a;
        exp_ext_mask = '0;
        for (int i = 0; i < NUM_BYTES; i++) begin
            a = {ext_port.addr, 2'(i)};
            exp_ext[8*i +: 8] = model_mem[a];
            if (model_known[a]) begin
                exp_ext_mask[8*i +: 8] = 8'hff;
            end
        end
    endtask

    // Core bytes first, external bytes on top
    task automatic apply_writes(bit core_wr);
        byte_addr_t a;
        if (core_wr) begin
            for (int i = 0; i < size_bytes(lsu_req.size); i++) begin
                a = lsu_req.addr + byte_addr_t'(i);
                model_mem[a]   = lsu_req.data[8*i +: 8];
                model_known[a] = 1'b1;
            end
        end
        if (ext_port.wren) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (ext_port.byteena[i]) begin
                    a = {ext_port.addr, 2'(i)};
                    model_mem[a]   = ext_port.data[8*i +: 8];
                    model_known[a] = 1'b1;
                end
            end
        end
    endtask

    task automatic report_mismatch(string field, word_t expected, word_t actual);
        errors++;
        $display("Error: time %0t, %s expected %h, got %h", $time, field, expected, actual);
    endtask

    // ------------------------------------------------------------
    // Sampling and comparison
    // ------------------------------------------------------------

    // Inputs are steady at the rising edge
    always @(posedge clock) begin
        bit mis;
        mis     = is_misaligned(lsu_req.size, lsu_req.addr[1:0]);
        started = 1'b1;
        if (rst) begin
            exp_valid      = 1'b0;
            exp_misaligned = 1'b0;
        end else begin
            exp_valid      = lsu_req.rd & ~mis;
            exp_misaligned = (lsu_req.rd | lsu_req.wr) & mis;
            if (lsu_req.rd | lsu_req.wr) begin
                accesses++;
            end
        end
        // Reads see the contents before this edge's writes
        if (exp_valid) begin
            predict_load(lsu_req.addr, lsu_req.size, lsu_req.is_unsigned);
        end
        predict_ext();
        apply_writes(lsu_req.wr & ~mis);
    end

    // Registered outputs are settled mid-cycle
    always @(negedge clock) begin
        if (started) begin
            if (load_valid !== exp_valid) begin
                report_mismatch("load_valid", {31'd0, exp_valid}, {31'd0, load_valid});
            end
            if (misaligned !== exp_misaligned) begin
                report_mismatch("misaligned", {31'd0, exp_misaligned}, {31'd0, misaligned});
            end
            if (exp_valid) begin
                loads++;
                if ((load_data & exp_load_mask) !== (exp_load & exp_load_mask)) begin
                    report_mismatch("load_data", exp_load, load_data);
                end
            end
            // Unwritten bytes are masked out
            if ((ext_q & exp_ext_mask) !== (exp_ext & exp_ext_mask)) begin
                report_mismatch("ext_q", exp_ext, ext_q);
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/gpc_dmem_tb.sv
// Data memory subsystem testbench

`timescale 1ns/1ps
`default_nettype none

module gpc_dmem_tb;

    import gpc_dmem_pkg::*;

    localparam int          NUM_ACCESSES  = 2000;
    localparam int          DRAIN_TIMEOUT = 100;
    // Small window so words are hit again and again
    localparam int          WINDOW_WORDS  = 16;
    localparam word_addr_t  WINDOW_BASE   = 10'h0a0;
    localparam logic [31:0] SEED          = 32'hbd13_48b1;

    logic      clock;
    logic      rst;
    lsu_req_t  lsu_req;
    word_t     load_data;
    logic      load_valid;
    logic      misaligned;
    mem_port_t ext_port;
    word_t     ext_q;

    int        error_count;
    int        access_count;
    int        load_count;
    int        sent;
    int        waited;
    bit        strobed;

    gpc_dmem_top gpc_dmem_top_inst (
        .clock      (clock),
        .rst        (rst),
        .lsu_req    (lsu_req),
        .load_data  (load_data),
        .load_valid (load_valid),
        .misaligned (misaligned),
        .ext_port   (ext_port),
        .ext_q      (ext_q)
    );

    gpc_dmem_checker gpc_dmem_checker_inst (
        .clock        (clock),
        .rst          (rst),
        .lsu_req      (lsu_req),
        .load_data    (load_data),
        .load_valid   (load_valid),
        .misaligned   (misaligned),
        .ext_port     (ext_port),
        .ext_q        (ext_q),
        .error_count  (error_count),
        .access_count (access_count),
        .load_count   (load_count)
    );

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------

    // Every word address gives a different word
    function automatic word_t fill_word(word_addr_t wa);
        return {2'b10, wa ^ 10'h155, wa, ~wa};
    endfunction

    // Whole window written through the external port
    task automatic preload_window();
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            @(negedge clock);
            ext_port.addr    = WINDOW_BASE + word_addr_t'(w);
            ext_port.wren    = 1'b1;
            ext_port.byteena = '1;
            ext_port.data    = fill_word(ext_port.addr);
        end
    endtask

    // One core request, roughly a tenth misaligned
    task automatic drive_core(output bit is_strobe);
        int op;
        int sz;
        int w;
        int lane;
        op   = $urandom_range(0, 9);
        w    = $urandom_range(0, WINDOW_WORDS - 1);
        lane = $urandom_range(0, 3);
        if ($urandom_range(0, 9) == 0) begin
            sz   = $urandom_range(1, 2);
            lane = (sz == 1) ? (lane | 1) : $urandom_range(1, 3);
        end else begin
            sz   = $urandom_range(0, 2);
            lane = (sz == 2) ? 0 : ((sz == 1) ? (lane & 2) : lane);
        end
        // Loads, stores, and an idle cycle now and then
        lsu_req.rd          = (op < 5);
        lsu_req.wr          = (op >= 5) && (op < 9);
        lsu_req.addr        = {WINDOW_BASE + word_addr_t'(w), 2'(lane)};
        lsu_req.size        = size_t'(sz);
        lsu_req.is_unsigned = 1'($urandom_range(0, 1));
        lsu_req.data        = $urandom();
        is_strobe           = lsu_req.rd | lsu_req.wr;
    endtask

    // External access, often on the core's word
    task automatic drive_ext();
        ext_port.wren    = ($urandom_range(0, 9) < 4);
        ext_port.byteena = byteena_t'($urandom_range(0, 15));
        ext_port.data    = $urandom();
        if ($urandom_range(0, 3) == 0) begin
            ext_port.addr = lsu_req.addr[ADRS_WIDTH-1:2];
        end else begin
            ext_port.addr = WINDOW_BASE + word_addr_t'($urandom_range(0, WINDOW_WORDS - 1));
        end
    endtask

    // ------------------------------------------------------------
    // Clock and run sequence
    // ------------------------------------------------------------

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        void'($urandom(SEED));
        rst      = 1'b1;
        lsu_req  = '0;
        ext_port = '0;
        // Aligned load, then misaligned load, both held off by reset
        lsu_req.rd   = 1'b1;
        lsu_req.addr = {WINDOW_BASE, 2'b00};
        lsu_req.size = SIZE_WORD;
        repeat (2) @(posedge clock);
        @(negedge clock);
        lsu_req.addr = {WINDOW_BASE, 2'b01};
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst     = 1'b0;
        lsu_req = '0;

        preload_window();

        sent = 0;
        while (sent < NUM_ACCESSES) begin
            @(negedge clock);
            drive_core(strobed);
            drive_ext();
            if (strobed) begin
                sent++;
            end
        end
        @(negedge clock);
        lsu_req  = '0;
        ext_port = '0;

        // Let the checker count the last strobes
        waited = 0;
        while ((access_count < NUM_ACCESSES) && (waited < DRAIN_TIMEOUT)) begin
            @(negedge clock);
            waited++;
        end
        @(posedge clock);

        if (access_count < NUM_ACCESSES) begin
            $display("Timeout: checker counted %0d of %0d accesses", access_count, NUM_ACCESSES);
            $display("ERRORS FOUND");
        end else begin
            $display("Checked %0d accesses and %0d loads, %0d errors",
                     access_count, load_count, error_count);
            if (error_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: gpc_dmem.f
verilog/gpc_dmem_pkg.sv
verilog/mem.sv
verilog/lsu_port.sv
verilog/gpc_dmem_top.sv
dv/gpc_dmem_checker.sv
dv/gpc_dmem_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module gpc_dmem_tb \
    -f gpc_dmem.f \
    -o gpc_dmem_sim

if ! ./obj_dir/gpc_dmem_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
